// File: include/l2_defines.svh
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// ***************************************************************************
// Cache geometry.
// ***************************************************************************

`define L2_NUM_BANKS 2
`define L2_LINE_BITS 128
// One enable per byte of a line.
`define L2_MASK_BITS 16

// ***************************************************************************
// Line address fields, low to high: bank, set, tag.
// ***************************************************************************

`define L2_ADDR_BITS 16
`define L2_BANK_BITS 1
`define L2_SET_BITS 4
`define L2_TAG_BITS 11
`define L2_WAY_BITS 2

// Echoed back with the response.
`define L2_ID_BITS 4

`endif

// File: hw/l2_pkg.sv
`default_nettype none

package l2_pkg;

	// Request kinds seen by every bank.
	typedef enum logic [1:0]
	{
		op_load = 2'd0,
		op_store = 2'd1,
		op_fill = 2'd2
	} l2_op_t;

endpackage

`default_nettype wire

// File: hw/l2_request_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_request_dispatch (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire req_valid,
	input wire l2_pkg::l2_op_t req_op,
	input wire [`L2_ADDR_BITS-1:0] req_addr,
	input wire [`L2_ID_BITS-1:0] req_id,
	input wire [`L2_LINE_BITS-1:0] req_data,
	input wire [`L2_MASK_BITS-1:0] req_mask,
	output logic [`L2_NUM_BANKS-1:0] bank_valid,
	output l2_pkg::l2_op_t bank_op,
	output logic [`L2_ADDR_BITS-1:0] bank_addr,
	output logic [`L2_ID_BITS-1:0] bank_id,
	output logic [`L2_LINE_BITS-1:0] bank_data,
	output logic [`L2_MASK_BITS-1:0] bank_mask
);
	localparam int BANK_BITS = `L2_BANK_BITS;

	// One-hot strobe, only the addressed bank sees the request.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bank_valid <= '0;
		else if (!stall)
		begin
			bank_valid <= '0;
			if (req_valid)
				bank_valid[req_addr[BANK_BITS-1:0]] <= 1'b1;
		end
	end

	// Request fields are shared by all banks.
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			bank_op <= req_op;
			bank_addr <= req_addr;
			bank_id <= req_id;
			bank_data <= req_data;
			bank_mask <= req_mask;
		end
	end

endmodule

`default_nettype wire

// File: hw/l2_tag_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_tag_stage (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire in_valid,
	input wire l2_pkg::l2_op_t in_op,
	input wire [`L2_ADDR_BITS-1:0] in_addr,
	input wire [`L2_ID_BITS-1:0] in_id,
	input wire [`L2_LINE_BITS-1:0] in_data,
	input wire [`L2_MASK_BITS-1:0] in_mask,
	output logic tg_valid,
	output l2_pkg::l2_op_t tg_op,
	output logic [`L2_ADDR_BITS-1:0] tg_addr,
	output logic [`L2_ID_BITS-1:0] tg_id,
	output logic [`L2_LINE_BITS-1:0] tg_data,
	output logic [`L2_MASK_BITS-1:0] tg_mask,
	output logic tg_hit,
	output logic [`L2_WAY_BITS-1:0] tg_way
);
	localparam int BANK_BITS = `L2_BANK_BITS;
	localparam int SET_BITS = `L2_SET_BITS;
	localparam int WAY_BITS = `L2_WAY_BITS;
	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int NUM_WAYS = 1 << WAY_BITS;

	logic [`L2_TAG_BITS-1:0] tag_mem [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid_mem [NUM_SETS];
	logic [WAY_BITS-1:0] rr_ptr [NUM_SETS];
	logic [SET_BITS-1:0] req_set;
	logic [`L2_TAG_BITS-1:0] req_tag;
	logic lookup_hit;
	logic [WAY_BITS-1:0] hit_way;
	logic [WAY_BITS-1:0] fill_way;
	logic fill_req;

	assign req_set = in_addr[BANK_BITS +: SET_BITS];
	assign req_tag = in_addr[BANK_BITS + SET_BITS +: `L2_TAG_BITS];
	assign fill_req = in_valid && in_op == l2_pkg::op_fill;

	// ***********************************************************************
	// Lookup across all ways of the set.
	// ***********************************************************************

	always_comb
	begin
		lookup_hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (valid_mem[req_set][w] && tag_mem[req_set][w] == req_tag)
			begin
				lookup_hit = 1'b1;
				hit_way = WAY_BITS'(w);
			end
		end
	end

	// A present line is refilled in place.
	assign fill_way = lookup_hit ? hit_way : rr_ptr[req_set];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tg_valid <= 1'b0;
			for (int s = 0; s < NUM_SETS; s++)
			begin
				valid_mem[s] <= '0;
				rr_ptr[s] <= '0;
			end
		end
		else if (!stall)
		begin
			tg_valid <= in_valid;
			if (fill_req)
			begin
				valid_mem[req_set][fill_way] <= 1'b1;
				if (!lookup_hit)
					rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			if (fill_req)
				tag_mem[req_set][fill_way] <= req_tag;
			tg_op <= in_op;
			tg_addr <= in_addr;
			tg_id <= in_id;
			tg_data <= in_data;
			tg_mask <= in_mask;
			tg_hit <= lookup_hit;
			tg_way <= fill_way;
		end
	end

endmodule

`default_nettype wire

// File: hw/l2_data_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_data_stage (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire tg_valid,
	input wire l2_pkg::l2_op_t tg_op,
	input wire [`L2_ADDR_BITS-1:0] tg_addr,
	input wire [`L2_ID_BITS-1:0] tg_id,
	input wire [`L2_LINE_BITS-1:0] tg_data,
	input wire [`L2_MASK_BITS-1:0] tg_mask,
	input wire tg_hit,
	input wire [`L2_WAY_BITS-1:0] tg_way,
	input wire [`L2_LINE_BITS-1:0] rd_line,
	input wire upd_en,
	input wire [`L2_WAY_BITS+`L2_SET_BITS-1:0] upd_index,
	input wire [`L2_LINE_BITS-1:0] upd_line,
	output logic [`L2_WAY_BITS+`L2_SET_BITS-1:0] rd_index,
	output logic dt_valid,
	output l2_pkg::l2_op_t dt_op,
	output logic [`L2_ADDR_BITS-1:0] dt_addr,
	output logic [`L2_ID_BITS-1:0] dt_id,
	output logic [`L2_LINE_BITS-1:0] dt_data,
	output logic [`L2_MASK_BITS-1:0] dt_mask,
	output logic dt_hit,
	output logic [`L2_WAY_BITS-1:0] dt_way,
	output logic [`L2_LINE_BITS-1:0] dt_old_line
);
	localparam int BANK_BITS = `L2_BANK_BITS;
	localparam int SET_BITS = `L2_SET_BITS;

	logic fwd_hit;

	// Array index is way above set.
	assign rd_index = {tg_way, tg_addr[BANK_BITS +: SET_BITS]};

	// Write stage is updating this very line in the current cycle.
	assign fwd_hit = upd_en && upd_index == rd_index;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			dt_valid <= 1'b0;
		else if (!stall)
			dt_valid <= tg_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			dt_op <= tg_op;
			dt_addr <= tg_addr;
			dt_id <= tg_id;
			dt_data <= tg_data;
			dt_mask <= tg_mask;
			dt_hit <= tg_hit;
			dt_way <= tg_way;
			dt_old_line <= fwd_hit ? upd_line : rd_line;
		end
	end

endmodule

`default_nettype wire

// File: hw/l2_write_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_write_stage (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire dt_valid,
	input wire l2_pkg::l2_op_t dt_op,
	input wire [`L2_ADDR_BITS-1:0] dt_addr,
	input wire [`L2_ID_BITS-1:0] dt_id,
	input wire [`L2_LINE_BITS-1:0] dt_data,
	input wire [`L2_MASK_BITS-1:0] dt_mask,
	input wire dt_hit,
	input wire [`L2_WAY_BITS-1:0] dt_way,
	input wire [`L2_LINE_BITS-1:0] dt_old_line,
	output logic upd_en,
	output logic [`L2_WAY_BITS+`L2_SET_BITS-1:0] upd_index,
	output logic [`L2_LINE_BITS-1:0] upd_line,
	output logic wr_valid,
	output l2_pkg::l2_op_t wr_op,
	output logic [`L2_ID_BITS-1:0] wr_id,
	output logic wr_hit,
	output logic [`L2_LINE_BITS-1:0] wr_line
);
	localparam int BANK_BITS = `L2_BANK_BITS;
	localparam int SET_BITS = `L2_SET_BITS;
	localparam int MASK_BITS = `L2_MASK_BITS;

	logic [`L2_LINE_BITS-1:0] merged_line;
	logic store_hit;
	logic fill;

	// Masked bytes from the store, the rest from the old line.
	always_comb
	begin
		for (int i = 0; i < MASK_BITS; i++)
			merged_line[i*8 +: 8] = dt_mask[i] ? dt_data[i*8 +: 8] : dt_old_line[i*8 +: 8];
	end

	assign store_hit = dt_valid && dt_hit && dt_op == l2_pkg::op_store;
	assign fill = dt_valid && dt_op == l2_pkg::op_fill;

	// ***********************************************************************
	// Array update, seen by the data stage in the same cycle.
	// ***********************************************************************

	assign upd_en = !stall && (store_hit || fill);
	assign upd_index = {dt_way, dt_addr[BANK_BITS +: SET_BITS]};
	assign upd_line = store_hit ? merged_line : dt_data;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wr_valid <= 1'b0;
		else if (!stall)
			wr_valid <= dt_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			wr_op <= dt_op;
			wr_id <= dt_id;
			wr_hit <= dt_hit;
			// Post-operation line.
			wr_line <= (store_hit || fill) ? upd_line : dt_old_line;
		end
	end

endmodule

`default_nettype wire

// File: hw/l2_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_bank (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire in_valid,
	input wire l2_pkg::l2_op_t in_op,
	input wire [`L2_ADDR_BITS-1:0] in_addr,
	input wire [`L2_ID_BITS-1:0] in_id,
	input wire [`L2_LINE_BITS-1:0] in_data,
	input wire [`L2_MASK_BITS-1:0] in_mask,
	output logic wr_valid,
	output l2_pkg::l2_op_t wr_op,
	output logic [`L2_ID_BITS-1:0] wr_id,
	output logic wr_hit,
	output logic [`L2_LINE_BITS-1:0] wr_line
);
	localparam int INDEX_BITS = `L2_WAY_BITS + `L2_SET_BITS;
	localparam int NUM_LINES = 1 << INDEX_BITS;

	logic [`L2_LINE_BITS-1:0] data_mem [NUM_LINES];

	logic tg_valid;
	l2_pkg::l2_op_t tg_op;
	logic [`L2_ADDR_BITS-1:0] tg_addr;
	logic [`L2_ID_BITS-1:0] tg_id;
	logic [`L2_LINE_BITS-1:0] tg_data;
	logic [`L2_MASK_BITS-1:0] tg_mask;
	logic tg_hit;
	logic [`L2_WAY_BITS-1:0] tg_way;

	logic dt_valid;
	l2_pkg::l2_op_t dt_op;
	logic [`L2_ADDR_BITS-1:0] dt_addr;
	logic [`L2_ID_BITS-1:0] dt_id;
	logic [`L2_LINE_BITS-1:0] dt_data;
	logic [`L2_MASK_BITS-1:0] dt_mask;
	logic dt_hit;
	logic [`L2_WAY_BITS-1:0] dt_way;
	logic [`L2_LINE_BITS-1:0] dt_old_line;

	logic [INDEX_BITS-1:0] rd_index;
	logic [`L2_LINE_BITS-1:0] rd_line;
	logic upd_en;
	logic [INDEX_BITS-1:0] upd_index;
	logic [`L2_LINE_BITS-1:0] upd_line;

	// Data array, one read port and one write port.
	assign rd_line = data_mem[rd_index];

	always_ff @(posedge clk)
	begin
		if (upd_en)
			data_mem[upd_index] <= upd_line;
	end

	l2_tag_stage i_tag (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.in_valid(in_valid), .in_op(in_op), .in_addr(in_addr), .in_id(in_id),
		.in_data(in_data), .in_mask(in_mask),
		.tg_valid(tg_valid), .tg_op(tg_op), .tg_addr(tg_addr), .tg_id(tg_id),
		.tg_data(tg_data), .tg_mask(tg_mask), .tg_hit(tg_hit), .tg_way(tg_way)
	);

	l2_data_stage i_data (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.tg_valid(tg_valid), .tg_op(tg_op), .tg_addr(tg_addr), .tg_id(tg_id),
		.tg_data(tg_data), .tg_mask(tg_mask), .tg_hit(tg_hit), .tg_way(tg_way),
		.rd_line(rd_line), .upd_en(upd_en), .upd_index(upd_index), .upd_line(upd_line),
		.rd_index(rd_index),
		.dt_valid(dt_valid), .dt_op(dt_op), .dt_addr(dt_addr), .dt_id(dt_id),
		.dt_data(dt_data), .dt_mask(dt_mask), .dt_hit(dt_hit), .dt_way(dt_way),
		.dt_old_line(dt_old_line)
	);

	l2_write_stage i_write (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.dt_valid(dt_valid), .dt_op(dt_op), .dt_addr(dt_addr), .dt_id(dt_id),
		.dt_data(dt_data), .dt_mask(dt_mask), .dt_hit(dt_hit), .dt_way(dt_way),
		.dt_old_line(dt_old_line),
		.upd_en(upd_en), .upd_index(upd_index), .upd_line(upd_line),
		.wr_valid(wr_valid), .wr_op(wr_op), .wr_id(wr_id), .wr_hit(wr_hit),
		.wr_line(wr_line)
	);

endmodule

`default_nettype wire

// File: hw/l2_response_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_response_merge (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire [`L2_NUM_BANKS-1:0] bank_wr_valid,
	input wire [`L2_NUM_BANKS-1:0][$bits(l2_pkg::l2_op_t)-1:0] bank_wr_op,
	input wire [`L2_NUM_BANKS-1:0][`L2_ID_BITS-1:0] bank_wr_id,
	input wire [`L2_NUM_BANKS-1:0] bank_wr_hit,
	input wire [`L2_NUM_BANKS-1:0][`L2_LINE_BITS-1:0] bank_wr_line,
	output logic resp_valid,
	output l2_pkg::l2_op_t resp_op,
	output logic [`L2_ID_BITS-1:0] resp_id,
	output logic resp_hit,
	output logic [`L2_LINE_BITS-1:0] resp_data
);
	localparam int NUM_BANKS = `L2_NUM_BANKS;

	l2_pkg::l2_op_t sel_op;
	logic [`L2_ID_BITS-1:0] sel_id;
	logic sel_hit;
	logic [`L2_LINE_BITS-1:0] sel_line;

	// At most one bank finishes per cycle.
	always_comb
	begin
		sel_op = l2_pkg::op_load;
		sel_id = '0;
		sel_hit = 1'b0;
		sel_line = '0;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			if (bank_wr_valid[b])
			begin
				sel_op = l2_pkg::l2_op_t'(bank_wr_op[b]);
				sel_id = bank_wr_id[b];
				sel_hit = bank_wr_hit[b];
				sel_line = bank_wr_line[b];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			resp_valid <= 1'b0;
			resp_op <= l2_pkg::op_load;
			resp_id <= '0;
			resp_hit <= 1'b0;
			resp_data <= '0;
		end
		else if (!stall)
		begin
			resp_valid <= |bank_wr_valid;
			resp_op <= sel_op;
			resp_id <= sel_id;
			resp_hit <= sel_hit;
			resp_data <= sel_line;
		end
	end

endmodule

`default_nettype wire

// File: hw/l2_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_cache_top (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire req_valid,
	input wire l2_pkg::l2_op_t req_op,
	input wire [`L2_ADDR_BITS-1:0] req_addr,
	input wire [`L2_ID_BITS-1:0] req_id,
	input wire [`L2_LINE_BITS-1:0] req_data,
	input wire [`L2_MASK_BITS-1:0] req_mask,
	output logic resp_valid,
	output l2_pkg::l2_op_t resp_op,
	output logic [`L2_ID_BITS-1:0] resp_id,
	output logic resp_hit,
	output logic [`L2_LINE_BITS-1:0] resp_data
);
	localparam int NUM_BANKS = `L2_NUM_BANKS;

	logic [NUM_BANKS-1:0] bank_valid;
	l2_pkg::l2_op_t bank_op;
	logic [`L2_ADDR_BITS-1:0] bank_addr;
	logic [`L2_ID_BITS-1:0] bank_id;
	logic [`L2_LINE_BITS-1:0] bank_data;
	logic [`L2_MASK_BITS-1:0] bank_mask;

	// Bank results, one slice per bank.
	wire [NUM_BANKS-1:0] bank_wr_valid;
	wire [NUM_BANKS-1:0][$bits(l2_pkg::l2_op_t)-1:0] bank_wr_op;
	wire [NUM_BANKS-1:0][`L2_ID_BITS-1:0] bank_wr_id;
	wire [NUM_BANKS-1:0] bank_wr_hit;
	wire [NUM_BANKS-1:0][`L2_LINE_BITS-1:0] bank_wr_line;

	l2_request_dispatch i_dispatch (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_id(req_id),
		.req_data(req_data), .req_mask(req_mask),
		.bank_valid(bank_valid), .bank_op(bank_op), .bank_addr(bank_addr),
		.bank_id(bank_id), .bank_data(bank_data), .bank_mask(bank_mask)
	);

	for (genvar g = 0; g < NUM_BANKS; g++)
	begin : g_bank
		l2_bank i_bank (
			.clk(clk), .rst_n(rst_n), .stall(stall),
			.in_valid(bank_valid[g]), .in_op(bank_op), .in_addr(bank_addr),
			.in_id(bank_id), .in_data(bank_data), .in_mask(bank_mask),
			.wr_valid(bank_wr_valid[g]), .wr_op(bank_wr_op[g]), .wr_id(bank_wr_id[g]),
			.wr_hit(bank_wr_hit[g]), .wr_line(bank_wr_line[g])
		);
	end

	l2_response_merge i_merge (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.bank_wr_valid(bank_wr_valid), .bank_wr_op(bank_wr_op), .bank_wr_id(bank_wr_id),
		.bank_wr_hit(bank_wr_hit), .bank_wr_line(bank_wr_line),
		.resp_valid(resp_valid), .resp_op(resp_op), .resp_id(resp_id),
		.resp_hit(resp_hit), .resp_data(resp_data)
	);

endmodule

`default_nettype wire

// File: tb/l2_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_defines.svh"

module l2_cache_tb;

	localparam int KIND_GAP = 0;
	localparam int KIND_NEXT = 1;
	localparam int KIND_STALL = 2;

	typedef struct {
		int kind;
		int cycles;
		string name;
		l2_pkg::l2_op_t op;
		logic [`L2_ADDR_BITS-1:0] addr;
		logic [`L2_ID_BITS-1:0] id;
		logic [`L2_LINE_BITS-1:0] data;
		logic [`L2_MASK_BITS-1:0] mask;
		logic hit;
		logic [`L2_LINE_BITS-1:0] exp_data;
	} trace_entry_t;

	logic clk;
	logic rst_n;
	logic stall;
	logic req_valid;
	l2_pkg::l2_op_t req_op;
	logic [`L2_ADDR_BITS-1:0] req_addr;
	logic [`L2_ID_BITS-1:0] req_id;
	logic [`L2_LINE_BITS-1:0] req_data;
	logic [`L2_MASK_BITS-1:0] req_mask;
	logic resp_valid;
	l2_pkg::l2_op_t resp_op;
	logic [`L2_ID_BITS-1:0] resp_id;
	logic resp_hit;
	logic [`L2_LINE_BITS-1:0] resp_data;

	trace_entry_t trace_q[$];
	trace_entry_t pending_q[$];
	int tests_run = 0;
	int tests_failed = 0;
	int other_errors = 0;
	bit loaded = 1'b0;

	l2_cache_top i_l2_cache_top (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr), .req_id(req_id),
		.req_data(req_data), .req_mask(req_mask),
		.resp_valid(resp_valid), .resp_op(resp_op), .resp_id(resp_id),
		.resp_hit(resp_hit), .resp_data(resp_data)
	);

	always #2 clk = ~clk;

	// ***********************************************************************
	// Trace parsing.
	// ***********************************************************************

	task automatic load_trace();
		int fd;
		int count;
		string line;
		string kind;
		string op_name;
		trace_entry_t e;
		fd = $fopen("tb/l2_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file tb/l2_trace.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			kind = "";
			void'($fgets(line, fd));
			count = $sscanf(line, "%s", kind);
			if (count < 1 || kind.len() == 0 || kind.getc(0) == "#")
				continue;
			if (kind == "stall")
			begin
				count = $sscanf(line, "%s %d", kind, e.cycles);
				e.kind = KIND_STALL;
				e.name = "stall";
			end
			else if (kind == "req" || kind == "next")
			begin
				count = $sscanf(line, "%s %s %s %h %h %h %h %h %h", kind, e.name, op_name,
					e.addr, e.id, e.data, e.mask, e.hit, e.exp_data);
				e.kind = (kind == "req") ? KIND_GAP : KIND_NEXT;
				if (op_name == "load")
					e.op = l2_pkg::op_load;
				else if (op_name == "store")
					e.op = l2_pkg::op_store;
				else if (op_name == "fill")
					e.op = l2_pkg::op_fill;
				else
					count = 0;
			end
			else
				count = 0;
			if ((e.kind == KIND_STALL && count != 2) || (e.kind != KIND_STALL && count != 9))
			begin
				$display("malformed trace line %s", line);
				other_errors++;
			end
			else
				trace_q.push_back(e);
		end
		$fclose(fd);
	endtask

	// ***********************************************************************
	// Stimulus.
	// ***********************************************************************

	task automatic idle_cycle();
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic issue_request(input trace_entry_t e);
		@(posedge clk);
		req_valid <= 1'b1;
		req_op <= e.op;
		req_addr <= e.addr;
		req_id <= e.id;
		req_data <= e.data;
		req_mask <= e.mask;
		pending_q.push_back(e);
	endtask

	// Stall covers the given number of rising edges.
	task automatic hold_stall(input int cycles);
		@(posedge clk);
		req_valid <= 1'b0;
		stall <= 1'b1;
		repeat (cycles) @(posedge clk);
		stall <= 1'b0;
	endtask

	task automatic check_response();
		trace_entry_t e;
		int fails;
		if (pending_q.size() == 0)
		begin
			$display("a response with id %0h came back with no request outstanding", resp_id);
			other_errors++;
			return;
		end
		e = pending_q.pop_front();
		fails = 0;
		assert (resp_id == e.id)
		else
		begin
			$display("error %s id expected %0h actual %0h", e.name, e.id, resp_id);
			fails++;
		end
		assert (resp_op == e.op)
		else
		begin
			$display("error %s op expected %0d actual %0d", e.name, e.op, resp_op);
			fails++;
		end
		assert (resp_hit == e.hit)
		else
		begin
			$display("error %s hit expected %0d actual %0d", e.name, e.hit, resp_hit);
			fails++;
		end
		// Line contents are only defined after a hit or a fill.
		if (e.hit || e.op == l2_pkg::op_fill)
		begin
			assert (resp_data == e.exp_data)
			else
			begin
				$display("error %s data expected %h actual %h", e.name, e.exp_data, resp_data);
				fails++;
			end
		end
		tests_run++;
		if (fails == 0)
			$display("pass %s", e.name);
		else
		begin
			tests_failed++;
			$display("fail %s", e.name);
		end
	endtask

	always @(negedge clk)
	begin
		if (rst_n && resp_valid && !stall)
			check_response();
	end

	initial
	begin
		int gap;
		trace_entry_t e;
		clk = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		req_valid = 1'b0;
		req_op = l2_pkg::op_load;
		req_addr = '0;
		req_id = '0;
		req_data = '0;
		req_mask = '0;
		void'($urandom(32'hb344_59bd));
		load_trace();
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < trace_q.size(); i++)
		begin
			e = trace_q[i];
			if (e.kind == KIND_STALL)
				hold_stall(e.cycles);
			else
			begin
				gap = (e.kind == KIND_GAP) ? $urandom_range(2, 0) : 0;
				repeat (gap) idle_cycle();
				issue_request(e);
			end
		end
		idle_cycle();
		while (pending_q.size() != 0)
			@(posedge clk);
		// Room for a stray extra response to show up.
		repeat (8) @(posedge clk);
		$display("%0d tests run, %0d passed, %0d failed, %0d other errors", tests_run,
			tests_run - tests_failed, tests_failed, other_errors);
		if (tests_failed == 0 && other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		wait (loaded);
		repeat (20 * trace_q.size() + 100) @(posedge clk);
		$display("watchdog expired with %0d responses still missing", pending_q.size());
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hw/l2_pkg.sv
hw/l2_request_dispatch.sv
hw/l2_tag_stage.sv
hw/l2_data_stage.sv
hw/l2_write_stage.sv
hw/l2_bank.sv
hw/l2_response_merge.sv
hw/l2_cache_top.sv
tb/l2_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the L2 cache testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Mdir obj_dir --top-module l2_cache_tb \
	-o l2_cache_sim -f filelist.f > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }
./obj_dir/l2_cache_sim > sim.log 2>&1 ; cat sim.log
grep -q "all tests passed" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb/l2_trace.txt
# Request lines hold kind name op addr id data mask hit expected_data in hex.
# Kind req waits 0 to 2 idle cycles first, next issues right away, stall n holds stall.
req t1_ld_miss_b0 load 0020 1 0 0000 0 0
req t1_ld_miss_b1 load 0021 2 0 0000 0 0
req t1_fill_b0 fill 0020 3 00112233445566778899aabbccddeeff 0000 0 00112233445566778899aabbccddeeff
req t1_fill_b1 fill 0021 4 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0000 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0
req t1_ld_hit_b0 load 0020 5 0 0000 1 00112233445566778899aabbccddeeff
req t1_ld_hit_b1 load 0021 6 0 0000 1 0f1e2d3c4b5a69788796a5b4c3d2e1f0
# Partial store merge and a store miss.
req t2_st_hit store 0020 7 a0a1a2a3a4a5a6a7a8a9aaabacadaeaf a5c3 1 a011a23344a566a7a8a9aabbccddaeaf
req t2_ld_merged load 0020 8 0 0000 1 a011a23344a566a7a8a9aabbccddaeaf
req t2_st_miss store 0041 9 ffffffffffffffffffffffffffffffff ffff 0 0
req t2_ld_st_miss load 0041 a 0 0000 0 0
req t2_ld_other load 0021 b 0 0000 1 0f1e2d3c4b5a69788796a5b4c3d2e1f0
# Five fills to bank 0 set 3.
req t3_fill_a fill 0026 c f1f1f1f1f1f1f1f1f1f1f1f1f1f1f1f1 0000 0 f1f1f1f1f1f1f1f1f1f1f1f1f1f1f1f1
req t3_fill_b fill 0046 d f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2 0000 0 f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2
req t3_fill_c fill 0066 e f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3 0000 0 f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3
req t3_fill_d fill 0086 f f4f4f4f4f4f4f4f4f4f4f4f4f4f4f4f4 0000 0 f4f4f4f4f4f4f4f4f4f4f4f4f4f4f4f4
req t3_fill_e fill 00a6 0 f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5 0000 0 f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5
req t3_ld_evicted load 0026 1 0 0000 0 0
req t3_ld_b load 0046 2 0 0000 1 f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2
req t3_ld_c load 0066 3 0 0000 1 f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3
req t3_ld_d load 0086 4 0 0000 1 f4f4f4f4f4f4f4f4f4f4f4f4f4f4f4f4
req t3_ld_e load 00a6 5 0 0000 1 f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5
# Back to back on one line.
req t4_fill fill 006b 6 0123456789abcdeffedcba9876543210 0000 0 0123456789abcdeffedcba9876543210
next t4_st_a store 006b 7 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a f00f 1 5a5a5a5a89abcdeffedcba985a5a5a5a
next t4_st_b store 006b 8 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c 0ff0 1 5a5a5a5a3c3c3c3c3c3c3c3c5a5a5a5a
next t4_ld load 006b 9 0 0000 1 5a5a5a5a3c3c3c3c3c3c3c3c5a5a5a5a
# Alternating banks.
req t5_b0_a load 0020 a 0 0000 1 a011a23344a566a7a8a9aabbccddaeaf
next t5_b1_a load 0021 b 0 0000 1 0f1e2d3c4b5a69788796a5b4c3d2e1f0
next t5_b0_b load 0046 c 0 0000 1 f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2f2
next t5_b1_b load 006b d 0 0000 1 5a5a5a5a3c3c3c3c3c3c3c3c5a5a5a5a
# Stalls with requests in flight.
req t6_ld_pre load 0066 e 0 0000 1 f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3f3
next t6_st store 0021 f 77777777777777777777777777777777 ffff 1 77777777777777777777777777777777
next t6_ld_st load 0021 0 0 0000 1 77777777777777777777777777777777
stall 6
next t6_ld_after load 0020 1 0 0000 1 a011a23344a566a7a8a9aabbccddaeaf
stall 3
req t6_ld_b1 load 0021 2 0 0000 1 77777777777777777777777777777777
next t6_ld_b0 load 00a6 3 0 0000 1 f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5f5
req t6_refill fill 0021 4 c0c1c2c3c4c5c6c7c8c9cacbcccdcecf 0000 1 c0c1c2c3c4c5c6c7c8c9cacbcccdcecf
next t6_ld_refill load 0021 5 0 0000 1 c0c1c2c3c4c5c6c7c8c9cacbcccdcecf
